// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_laser310
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0 --timescale 1ns/100ps
PASS_MSG ?= TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the simulator printed the pass line
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)

// File: source/laser310_core.sv
`timescale 1ns/100ps
`default_nettype none

module laser310_core (
	input wire CLK50MHZ,
	input wire RESET_N,
	input wire laser_pkg::addr_t cpu_addr_i,
	input wire laser_pkg::data_t cpu_wdata_i,
	input wire cpu_mreq_i,
	input wire cpu_iorq_i,
	input wire cpu_rd_i,
	input wire cpu_wr_i,
	input wire key_strobe_i,
	input wire key_pressed_i,
	input wire laser_pkg::data_t key_code_i,
	input wire cass_in_i,
	output laser_pkg::data_t cpu_rdata_o,
	output logic [1:0] speaker_o,
	output logic cass_out_o
);
	import laser_pkg::*;

	region_e region;
	data_t mem_rdata;
	data_t key_data;

	laser_bus_if bus0 ();

	// CPU strobes straight onto the internal bus
	assign bus0.addr = cpu_addr_i;
	assign bus0.wdata = cpu_wdata_i;
	assign bus0.mreq = cpu_mreq_i;
	assign bus0.iorq = cpu_iorq_i;
	assign bus0.rd = cpu_rd_i;
	assign bus0.wr = cpu_wr_i;

	laser_keyboard kbd0 (
		.CLK50MHZ(CLK50MHZ),
		.RESET_N(RESET_N),
		.key_strobe_i(key_strobe_i),
		.key_pressed_i(key_pressed_i),
		.key_code_i(key_code_i),
		.cass_in_i(cass_in_i),
		.bus(bus0.kbd),
		.key_data_o(key_data)
	);

	laser_mem_map mem0 (
		.CLK50MHZ(CLK50MHZ),
		.RESET_N(RESET_N),
		.bus(bus0.mem),
		.region_o(region),
		.mem_rdata_o(mem_rdata),
		.speaker_o(speaker_o),
		.cass_out_o(cass_out_o)
	);

	laser_read_mux mux0 (
		.CLK50MHZ(CLK50MHZ),
		.RESET_N(RESET_N),
		.bus(bus0.mux),
		.region_i(region),
		.mem_rdata_i(mem_rdata),
		.key_data_i(key_data),
		.cpu_rdata_o(cpu_rdata_o)
	);

endmodule

`default_nettype wire

// File: source/laser_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

interface laser_bus_if;
	import laser_pkg::*;

	cpu_addr_u addr;
	data_t wdata;
	logic mreq;
	logic iorq;
	logic rd;
	logic wr;

	modport master (output addr, output wdata, output mreq, output iorq, output rd, output wr);

	modport mem (input addr, input wdata, input mreq, input iorq, input rd, input wr);

	// Row select only
	modport kbd (input addr);

	// Read strobe gates the output registers
	modport mux (input rd);

endinterface

`default_nettype wire

// File: source/laser_keyboard.sv
`timescale 1ns/100ps
`default_nettype none

module laser_keyboard (
	input wire CLK50MHZ,
	input wire RESET_N,
	input wire key_strobe_i,
	input wire key_pressed_i,
	input wire laser_pkg::data_t key_code_i,
	input wire cass_in_i,
	laser_bus_if.kbd bus,
	output laser_pkg::data_t key_data_o
);
	import laser_pkg::*;

	// Matrix, 0 means pressed
	//      c5  c4  c3  c2   c1  c0
	// r0   R   Q   E   -    W   T
	// r1   F   A   D   CTRL S   G
	// r2   V   Z   C   SHFT X   B
	// r3   4   1   3   -    2   5
	// r4   M   SPC ,   -    .   N
	// r5   7   0   8   -    9   6
	// r6   U   P   I   RET  O   Y
	// r7   J   ;   K   :    L   H
	logic [KEY_ROWS-1:0][KEY_COLS-1:0] key_mat;
	logic [KEY_ROWS-1:0][KEY_COLS-1:0] key_eff;

	// Keys not on the matrix
	// 0 rshift, 1 up, 2 down, 3 left, 4 right, 5 esc, 6 bksp
	logic [6:0] key_ext;
	logic [KEY_ROWS-1:0] col_bits;

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			key_mat <= '1;
			key_ext <= '1;
		end
		else if (key_strobe_i)
		begin
			case (key_code_i)
				KC_Q: key_mat[0][4] <= ~key_pressed_i;
				KC_A: key_mat[1][4] <= ~key_pressed_i;
				KC_CTRL: key_mat[1][2] <= ~key_pressed_i;
				KC_Z: key_mat[2][4] <= ~key_pressed_i;
				KC_LSHIFT: key_mat[2][2] <= ~key_pressed_i;
				KC_1: key_mat[3][4] <= ~key_pressed_i;
				KC_M: key_mat[4][5] <= ~key_pressed_i;
				KC_SPACE: key_mat[4][4] <= ~key_pressed_i;
				KC_COMMA: key_mat[4][3] <= ~key_pressed_i;
				KC_PERIOD: key_mat[4][1] <= ~key_pressed_i;
				KC_N: key_mat[4][0] <= ~key_pressed_i;
				KC_0: key_mat[5][4] <= ~key_pressed_i;
				KC_MINUS: key_mat[5][2] <= ~key_pressed_i;
				KC_P: key_mat[6][4] <= ~key_pressed_i;
				KC_RETURN: key_mat[6][2] <= ~key_pressed_i;
				KC_L: key_mat[7][1] <= ~key_pressed_i;
				KC_RSHIFT: key_ext[0] <= ~key_pressed_i;
				KC_UP: key_ext[1] <= ~key_pressed_i;
				KC_DOWN: key_ext[2] <= ~key_pressed_i;
				KC_LEFT: key_ext[3] <= ~key_pressed_i;
				KC_RIGHT: key_ext[4] <= ~key_pressed_i;
				KC_ESC: key_ext[5] <= ~key_pressed_i;
				KC_BKSP: key_ext[6] <= ~key_pressed_i;
				default: ;	// Unmapped codes ignored
			endcase
		end
	end

	// Fold the extension keys into Ctrl plus a partner key
	always_comb
	begin
		key_eff = key_mat;
		key_eff[1][2] = key_mat[1][2] & (&key_ext[6:1]);	// Ctrl
		key_eff[2][2] = key_mat[2][2] & key_ext[0];	// Either shift
		key_eff[4][1] = key_mat[4][1] & key_ext[1];	// Up is Ctrl .
		key_eff[4][4] = key_mat[4][4] & key_ext[2];	// Down is Ctrl space
		key_eff[4][5] = key_mat[4][5] & key_ext[3] & key_ext[6];	// Left, bksp
		key_eff[4][3] = key_mat[4][3] & key_ext[4];	// Right is Ctrl ,
		key_eff[5][2] = key_mat[5][2] & key_ext[5];	// Esc is Ctrl -
	end

	// A column reads 0 if any selected row has that key down
	always_comb
	begin
		key_data_o = 8'hFF;
		col_bits = '1;
		for (int c = 0; c < KEY_COLS; c++)
		begin
			for (int r = 0; r < KEY_ROWS; r++)
				col_bits[r] = key_eff[r][c];
			key_data_o[c] = &(bus.addr.kbd.row_sel | col_bits);
		end
		key_data_o[6] = ~cass_in_i;	// Tape input, inverted
		key_data_o[7] = 1'b1;
	end

	// Scan-code strobe is a single-cycle pulse
	a_strobe_pulse: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		key_strobe_i |=> !key_strobe_i);

endmodule

`default_nettype wire

// File: source/laser_mem_map.sv
`timescale 1ns/100ps
`default_nettype none

module laser_mem_map (
	input wire CLK50MHZ,
	input wire RESET_N,
	laser_bus_if.mem bus,
	output laser_pkg::region_e region_o,
	output laser_pkg::data_t mem_rdata_o,
	output logic [1:0] speaker_o,
	output logic cass_out_o
);
	import laser_pkg::*;

	data_t vram [2**VRAM_AW];
	data_t ram [2**RAM_AW];
	data_t vram_q;
	data_t ram_q;
	data_t io_latch;
	logic vram_sel_q;	// Which array the last read came from
	logic mem_wr;
	addr_t ram_off;

	// 2 KB page decode
	always_comb
	begin
		if (bus.addr.mem.page == PAGE_IO)
			region_o = REGION_IO;
		else if (bus.addr.mem.page == PAGE_VRAM)
			region_o = REGION_VRAM;
		else if (bus.addr.mem.page >= PAGE_RAM_FIRST && bus.addr.mem.page <= PAGE_RAM_LAST)
			region_o = REGION_RAM;
		else
			region_o = REGION_NONE;	// ROM area, 6000 and C000 up
	end

	// Memory write, never an I/O cycle
	assign mem_wr = bus.mreq & bus.wr & ~bus.iorq;

	// System RAM starts at 7800
	assign ram_off = bus.addr - {PAGE_RAM_FIRST, {VRAM_AW{1'b0}}};

	always_ff @(posedge CLK50MHZ)
	begin
		if (mem_wr && region_o == REGION_VRAM)
			vram[bus.addr.mem.offset] <= bus.wdata;
		if (bus.rd)
			vram_q <= vram[bus.addr.mem.offset];	// Old data on a same-edge write
	end

	always_ff @(posedge CLK50MHZ)
	begin
		if (mem_wr && region_o == REGION_RAM)
			ram[ram_off[RAM_AW-1:0]] <= bus.wdata;
		if (bus.rd)
			ram_q <= ram[ram_off[RAM_AW-1:0]];
	end

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			io_latch <= '0;
			vram_sel_q <= 1'b0;
		end
		else
		begin
			if (mem_wr && region_o == REGION_IO)
				io_latch <= bus.wdata;
			if (bus.rd)
				vram_sel_q <= (region_o == REGION_VRAM);
		end
	end

	assign mem_rdata_o = vram_sel_q ? vram_q : ram_q;

	// Speaker pair is driven in antiphase by software
	assign speaker_o = {io_latch[IO_BIT_SPK_A], io_latch[IO_BIT_SPK_B]};
	assign cass_out_o = io_latch[IO_BIT_CASS];

	a_no_rd_wr: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		bus.mreq |-> !(bus.rd && bus.wr));

endmodule

`default_nettype wire

// File: source/laser_pkg.sv
`default_nettype none

package laser_pkg;

	localparam int VRAM_AW = 11;	// 2 KB video RAM, also one page
	localparam int RAM_AW = 14;	// 16 KB system RAM
	localparam int KEY_ROWS = 8;
	localparam int KEY_COLS = 6;

	// Bits of the 6800 output latch
	localparam int IO_BIT_SPK_A = 0;
	localparam int IO_BIT_SPK_B = 5;
	localparam int IO_BIT_CASS = 2;

	typedef logic [15:0] addr_t;
	typedef logic [7:0] data_t;

	// Same address word, seen by the memory decoder or by the key matrix
	typedef union packed {
		struct packed {
			logic [15-VRAM_AW:0] page;
			logic [VRAM_AW-1:0] offset;
		} mem;
		struct packed {
			logic [7:0] unused;
			logic [7:0] row_sel;	// Low bit selects a row
		} kbd;
	} cpu_addr_u;

	typedef enum logic [1:0] {
		REGION_NONE,
		REGION_IO,
		REGION_VRAM,
		REGION_RAM
	} region_e;

	localparam logic [4:0] PAGE_IO = 5'b01101;	// 6800-6FFF
	localparam logic [4:0] PAGE_VRAM = 5'b01110;	// 7000-77FF
	localparam logic [4:0] PAGE_RAM_FIRST = 5'b01111;	// 7800
	localparam logic [4:0] PAGE_RAM_LAST = 5'b10110;	// up to B7FF

	// PS/2 set 2 make codes
	localparam data_t KC_CTRL = 8'h14;
	localparam data_t KC_LSHIFT = 8'h12;
	localparam data_t KC_RSHIFT = 8'h59;
	localparam data_t KC_UP = 8'h75;
	localparam data_t KC_DOWN = 8'h72;
	localparam data_t KC_LEFT = 8'h6B;
	localparam data_t KC_RIGHT = 8'h74;
	localparam data_t KC_ESC = 8'h76;
	localparam data_t KC_BKSP = 8'h66;
	localparam data_t KC_SPACE = 8'h29;
	localparam data_t KC_COMMA = 8'h41;
	localparam data_t KC_PERIOD = 8'h49;
	localparam data_t KC_MINUS = 8'h4E;
	localparam data_t KC_RETURN = 8'h5A;
	localparam data_t KC_Q = 8'h15;
	localparam data_t KC_A = 8'h1C;
	localparam data_t KC_Z = 8'h1A;
	localparam data_t KC_N = 8'h31;
	localparam data_t KC_M = 8'h3A;
	localparam data_t KC_P = 8'h4D;
	localparam data_t KC_L = 8'h4B;
	localparam data_t KC_1 = 8'h16;
	localparam data_t KC_0 = 8'h45;

endpackage

`default_nettype wire

// File: source/laser_read_mux.sv
`timescale 1ns/100ps
`default_nettype none

module laser_read_mux (
	input wire CLK50MHZ,
	input wire RESET_N,
	laser_bus_if.mux bus,
	input wire laser_pkg::region_e region_i,
	input wire laser_pkg::data_t mem_rdata_i,
	input wire laser_pkg::data_t key_data_i,
	output laser_pkg::data_t cpu_rdata_o
);
	import laser_pkg::*;

	region_e region_q;
	data_t key_q;

	// Only a read cycle moves the selection
	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
			region_q <= REGION_NONE;
		else if (bus.rd)
			region_q <= region_i;
	end

	// Key byte lines up with the synchronous RAM read
	always_ff @(posedge CLK50MHZ)
	begin
		if (bus.rd)
			key_q <= key_data_i;
	end

	always_comb
	begin
		case (region_q)
			REGION_IO: cpu_rdata_o = key_q;
			REGION_VRAM, REGION_RAM: cpu_rdata_o = mem_rdata_i;
			default: cpu_rdata_o = 8'hFF;	// Open bus
		endcase
	end

	a_none_reads_ff: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		(bus.rd && region_i == REGION_NONE) |=> (cpu_rdata_o == 8'hFF));

endmodule

`default_nettype wire

// File: src.f
source/laser_pkg.sv
source/laser_bus_if.sv
source/laser_keyboard.sv
source/laser_mem_map.sv
source/laser_read_mux.sv
source/laser310_core.sv
tb/tb_laser310.sv

// File: tb/tb_laser310.sv
`timescale 1ns/100ps
`default_nettype none

module tb_laser310;
	import laser_pkg::*;

	localparam int CYCLE_LIMIT = 4000;	// About three times the full run
	localparam int N_RAM = 200;
	localparam int N_VRAM = 200;

	logic CLK50MHZ;
	logic RESET_N;
	addr_t cpu_addr_i;
	data_t cpu_wdata_i;
	logic cpu_mreq_i, cpu_iorq_i, cpu_rd_i, cpu_wr_i;
	logic key_strobe_i, key_pressed_i, cass_in_i;
	data_t key_code_i;
	data_t cpu_rdata_o;
	logic [1:0] speaker_o;
	logic cass_out_o;

	// Reference model
	data_t ram_m [2**RAM_AW];
	data_t vram_m [2**VRAM_AW];
	logic [KEY_ROWS-1:0][KEY_COLS-1:0] key_m;	// 0 is pressed
	logic [1:0] spk_m, spk_q;
	logic cass_m, cass_q, cass_next;
	logic chk_d, chk_q;
	data_t exp_d, exp_q;
	string test_name;
	int cycle_cnt = 0;
	addr_t a;
	data_t d;
	addr_t ram_addrs[$];
	addr_t vram_addrs[$];

	laser310_core dut0 (.*);

	initial
	begin
		CLK50MHZ = 1'b0;
		forever #10 CLK50MHZ = ~CLK50MHZ;
	end

	// Model lines up with the DUT registers
	always @(posedge CLK50MHZ)
	begin
		chk_q <= chk_d;
		exp_q <= exp_d;
		spk_q <= spk_m;
		cass_q <= cass_m;
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
		begin
			$display("Timeout: run still busy after %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	a_rdata: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		chk_q |-> (cpu_rdata_o == exp_q))
	else
	begin
		$display("Error: %s expected %h actual %h", test_name, $sampled(exp_q),
			$sampled(cpu_rdata_o));
		$display("TEST FAILED");
		$fatal(1, "read data mismatch");
	end

	a_io_out: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		(speaker_o == spk_q) && (cass_out_o == cass_q))
	else
	begin
		$display("Error: %s expected speaker %b cass %b actual speaker %b cass %b",
			test_name, $sampled(spk_q), $sampled(cass_q), $sampled(speaker_o),
			$sampled(cass_out_o));
		$display("TEST FAILED");
		$fatal(1, "output latch mismatch");
	end

	function automatic logic [RAM_AW-1:0] ram_index(input addr_t addr);
		addr_t off;
		off = addr - 16'h7800;
		return off[RAM_AW-1:0];
	endfunction

	// Any selected row with the key down pulls its column low
	function automatic data_t key_byte_model(input logic [7:0] row_sel, input logic cass);
		data_t b;
		b = 8'hFF;
		for (int c = 0; c < KEY_COLS; c++)
			for (int r = 0; r < KEY_ROWS; r++)
				if (!row_sel[r] && !key_m[r][c])
					b[c] = 1'b0;
		b[6] = ~cass;
		return b;
	endfunction

	task automatic drive_cycle(input addr_t addr, input data_t wdata, input logic mreq,
		input logic iorq, input logic rd, input logic wr, input logic chk, input data_t exp);
		@(negedge CLK50MHZ);
		cpu_addr_i = addr;
		cpu_wdata_i = wdata;
		cpu_mreq_i = mreq;
		cpu_iorq_i = iorq;
		cpu_rd_i = rd;
		cpu_wr_i = wr;
		key_strobe_i = 1'b0;
		cass_in_i = cass_next;
		chk_d = chk;
		exp_d = exp;
	endtask

	task automatic idle(input int n);
		repeat (n) drive_cycle(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'hFF);
	endtask

	task automatic mem_write(input addr_t addr, input data_t wdata);
		drive_cycle(addr, wdata, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 8'hFF);
	endtask

	task automatic mem_read(input addr_t addr, input data_t exp);
		drive_cycle(addr, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, exp);
	endtask

	task automatic begin_test(input string name);
		idle(2);	// Drain pending checks first
		test_name = name;
	endtask

	task automatic key_event(input data_t code, input logic pressed);
		idle(1);
		key_strobe_i = 1'b1;
		key_code_i = code;
		key_pressed_i = pressed;
	endtask

	task automatic key_read(input logic [7:0] row_sel);
		addr_t ka;
		ka = {PAGE_IO, 3'($urandom), row_sel};
		cass_next = 1'($urandom);
		mem_read(ka, key_byte_model(row_sel, cass_next));
	endtask

	// Extension keys also hold Ctrl
	task automatic check_key(input data_t code, input int row, input int col,
		input logic with_ctrl);
		key_event(code, 1'b1);
		key_m[row][col] = 1'b0;
		if (with_ctrl)
			key_m[1][2] = 1'b0;
		for (int r = 0; r < KEY_ROWS; r++)
			key_read(~(8'h01 << r));
		key_read(8'h00);
		key_read(data_t'($urandom));
		key_event(code, 1'b0);
		key_m[row][col] = 1'b1;
		key_m[1][2] = 1'b1;
		key_read(~(8'h01 << row));
		key_read(8'hFD);	// Ctrl row
	endtask

	initial
	begin
		void'($urandom(79779));
		RESET_N = 1'b0;
		cpu_addr_i = '0;
		cpu_wdata_i = '0;
		cpu_mreq_i = 1'b0;
		cpu_iorq_i = 1'b0;
		cpu_rd_i = 1'b0;
		cpu_wr_i = 1'b0;
		key_strobe_i = 1'b0;
		key_pressed_i = 1'b0;
		key_code_i = '0;
		cass_in_i = 1'b0;
		cass_next = 1'b0;
		chk_d = 1'b0;
		exp_d = 8'hFF;
		spk_m = '0;
		cass_m = 1'b0;
		key_m = '1;
		test_name = "reset";
		repeat (16) @(posedge CLK50MHZ);
		@(negedge CLK50MHZ);
		RESET_N = 1'b1;
		drive_cycle(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 8'hFF);	// Reset value

		begin_test("ram");
		repeat (N_RAM)
		begin
			a = 16'h7800 + addr_t'($urandom_range(16383));
			d = data_t'($urandom);
			ram_m[ram_index(a)] = d;
			ram_addrs.push_back(a);
			mem_write(a, d);
		end
		foreach (ram_addrs[i])
			mem_read(ram_addrs[i], ram_m[ram_index(ram_addrs[i])]);

		begin_test("vram");
		repeat (N_VRAM)
		begin
			a = 16'h7000 + addr_t'($urandom_range(2047));
			d = data_t'($urandom);
			vram_m[a[VRAM_AW-1:0]] = d;
			vram_addrs.push_back(a);
			mem_write(a, d);
		end
		foreach (vram_addrs[i])
			mem_read(vram_addrs[i], vram_m[vram_addrs[i][VRAM_AW-1:0]]);
		foreach (ram_addrs[i])
			mem_read(ram_addrs[i], ram_m[ram_index(ram_addrs[i])]);	// RAM untouched

		begin_test("io_latch");
		repeat (16)
		begin
			a = 16'h6800 + addr_t'($urandom_range(2047));
			d = data_t'($urandom);
			mem_write(a, d);
			spk_m = {d[IO_BIT_SPK_A], d[IO_BIT_SPK_B]};	// Latched at the coming edge
			cass_m = d[IO_BIT_CASS];
		end
		repeat (8)
			drive_cycle(16'h6800 + addr_t'($urandom_range(2047)), data_t'($urandom),
				1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 8'hFF);

		begin_test("keyboard");
		check_key(KC_Q, 0, 4, 1'b0);
		check_key(KC_A, 1, 4, 1'b0);
		check_key(KC_Z, 2, 4, 1'b0);
		check_key(KC_1, 3, 4, 1'b0);
		check_key(KC_M, 4, 5, 1'b0);
		check_key(KC_N, 4, 0, 1'b0);
		check_key(KC_0, 5, 4, 1'b0);
		check_key(KC_P, 6, 4, 1'b0);
		check_key(KC_L, 7, 1, 1'b0);

		begin_test("ext_keys");
		check_key(KC_UP, 4, 1, 1'b1);
		check_key(KC_DOWN, 4, 4, 1'b1);
		check_key(KC_LEFT, 4, 5, 1'b1);
		check_key(KC_RIGHT, 4, 3, 1'b1);
		check_key(KC_ESC, 5, 2, 1'b1);
		check_key(KC_BKSP, 4, 5, 1'b1);

		begin_test("unmapped");
		repeat (20)
		begin
			mem_read(addr_t'($urandom_range(16'h67FF)), 8'hFF);
			mem_read(16'hC000 + addr_t'($urandom_range(16'h3FFF)), 8'hFF);
		end

		idle(4);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire
